// File: include/fir_defs.svh
/* FIR shared parameters */

`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

//************************************************************
// widths
//************************************************************

// samples, taps, results and register words
`define FIR_DATA_W      32

// register port byte address
`define FIR_ADDR_W      12

//************************************************************
// filter and buffer sizes
//************************************************************

`define FIR_NUM_TAPS    11

// input stream buffer entries
`define FIR_FIFO_DEPTH  4

//************************************************************
// register map, tap i at FIR_ADDR_TAP0 + 4*i
//************************************************************

`define FIR_ADDR_CTRL   12'h000
`define FIR_ADDR_LEN    12'h010
`define FIR_ADDR_TAP0   12'h020

`endif

// File: source/fir_pkg.sv
/* FIR shared types */

`include "fir_defs.svh"

package fir_pkg;

    //************************************************************
    // basic words
    //************************************************************

    // one sample, tap coefficient or filter result
    typedef logic [`FIR_DATA_W-1:0] fir_data_t;

    // register port address
    typedef logic [`FIR_ADDR_W-1:0] fir_addr_t;

    //************************************************************
    // stream and configuration types
    //************************************************************

    // one stream beat, same layout on input and output side
    typedef struct packed {
        fir_data_t data;
        logic      last;
    } fir_axis_beat_t;

    // whole coefficient bank, element i is tap i
    typedef fir_data_t [`FIR_NUM_TAPS-1:0] fir_tap_bank_t;

    // control word at 0x00
    // writes are decoded by field, reads return the raw word
    typedef union packed {
        fir_data_t raw;
        struct packed {
            // always zero
            logic [`FIR_DATA_W-4:0] reserved;
            // no run in progress
            logic                   ap_idle;
            // last output accepted, cleared by a read
            logic                   ap_done;
            // start request, one cycle wide
            logic                   ap_start;
        } f;
    } fir_ctrl_word_u;

endpackage

// File: source/fir_ctrl_regs.sv
/* FIR register port and run control */

`timescale 1ns/1ps

`include "fir_defs.svh"

module fir_ctrl_regs
(
    input  logic                    clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    input  fir_pkg::fir_addr_t      awaddr,
    input  logic                    wvalid,
    input  fir_pkg::fir_data_t      wdata,
    input  logic                    arvalid,
    input  fir_pkg::fir_addr_t      araddr,
    input  logic                    rready,
    input  logic                    run_done,
    output logic                    awready,
    output logic                    wready,
    output logic                    arready,
    output logic                    rvalid,
    output fir_pkg::fir_data_t      rdata,
    output logic                    run_start,
    output logic                    run_active,
    output fir_pkg::fir_data_t      data_length,
    output fir_pkg::fir_tap_bank_t  taps
);
    import fir_pkg::*;

    localparam int TAP_IDX_W = $clog2(`FIR_NUM_TAPS);
    // highest valid tap address
    localparam fir_addr_t TAP_LAST = fir_addr_t'(`FIR_ADDR_TAP0 + 4 * (`FIR_NUM_TAPS - 1));

    fir_ctrl_word_u          ctrl_q;
    fir_ctrl_word_u          wr_ctrl;
    logic                    wr_fire;
    logic                    rd_fire;
    logic                    wr_ctrl_hit;
    logic                    wr_len_hit;
    logic                    wr_tap_hit;
    logic [TAP_IDX_W-1:0]    wr_tap_idx;
    logic [TAP_IDX_W-1:0]    rd_tap_idx;
    fir_data_t               rd_word;

    // word aligned and inside the tap window
    function automatic logic tap_hit(input fir_addr_t addr);
        tap_hit = (addr >= `FIR_ADDR_TAP0) && (addr <= TAP_LAST) && (addr[1:0] == 2'b00);
    endfunction

    // byte offset from the first tap, divided by four
    function automatic logic [TAP_IDX_W-1:0] tap_index(input fir_addr_t addr);
        fir_addr_t offset;
        offset    = addr - `FIR_ADDR_TAP0;
        tap_index = offset[TAP_IDX_W+1:2];
    endfunction

    //************************************************************
    // write side, address and data taken together
    //************************************************************

    assign wr_fire     = awvalid & wvalid;
    assign awready     = wr_fire;
    assign wready      = wr_fire;
    assign wr_ctrl.raw = wdata;
    assign wr_ctrl_hit = wr_fire & (awaddr == `FIR_ADDR_CTRL);
    assign wr_len_hit  = wr_fire & (awaddr == `FIR_ADDR_LEN);
    assign wr_tap_hit  = wr_fire & tap_hit(awaddr);
    assign wr_tap_idx  = tap_index(awaddr);

    // configuration words
    always_ff @(posedge clk)
    begin
        if (wr_len_hit)
            data_length <= wdata;
        if (wr_tap_hit)
            taps[wr_tap_idx] <= wdata;
    end

    //************************************************************
    // control word
    //************************************************************

    always_ff @(posedge clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            ctrl_q.raw       <= '0;
            ctrl_q.f.ap_idle <= 1'b1;
        end
        else
        begin
            // start is seen by the engine for one cycle, then the run is busy
            if (ctrl_q.f.ap_start)
            begin
                ctrl_q.f.ap_start <= 1'b0;
                ctrl_q.f.ap_idle  <= 1'b0;
            end
            else if (wr_ctrl_hit && wr_ctrl.f.ap_start && ctrl_q.f.ap_idle)
                ctrl_q.f.ap_start <= 1'b1;

            // end of run wins over a status read in the same cycle
            if (run_done)
            begin
                ctrl_q.f.ap_done <= 1'b1;
                ctrl_q.f.ap_idle <= 1'b1;
            end
            else if (rd_fire && (araddr == `FIR_ADDR_CTRL))
                ctrl_q.f.ap_done <= 1'b0;
        end
    end

    assign run_start  = ctrl_q.f.ap_start;
    assign run_active = ~ctrl_q.f.ap_idle;

    //************************************************************
    // read side
    //************************************************************

    // one read outstanding at a time
    assign arready    = arvalid & ~rvalid;
    assign rd_fire    = arvalid & arready;
    assign rd_tap_idx = tap_index(araddr);

    always_comb
    begin
        if (araddr == `FIR_ADDR_CTRL)
            rd_word = ctrl_q.raw;
        else if (araddr == `FIR_ADDR_LEN)
            rd_word = data_length;
        else if (tap_hit(araddr))
            rd_word = taps[rd_tap_idx];
        else
            rd_word = '1;
    end

    always_ff @(posedge clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // data held until the next accepted address
    always_ff @(posedge clk)
    begin
        if (rd_fire)
            rdata <= rd_word;
    end

endmodule

// File: source/fir_sample_fifo.sv
/* FIR input sample buffer */

`timescale 1ns/1ps

`include "fir_defs.svh"

module fir_sample_fifo
(
    input  logic                     clk,
    input  logic                     axis_rst_n,
    input  logic                     run_active,
    input  logic                     ss_tvalid,
    input  fir_pkg::fir_axis_beat_t  ss_beat,
    input  logic                     fifo_pop,
    output logic                     ss_tready,
    output logic                     fifo_valid,
    output fir_pkg::fir_axis_beat_t  fifo_beat
);
    import fir_pkg::*;

    localparam int DEPTH = `FIR_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fir_axis_beat_t      mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;
    logic                push;
    logic                pop;

    // only take samples during a run and while there is room
    assign ss_tready  = run_active & (count != (PTR_W+1)'(DEPTH));
    assign push       = ss_tvalid & ss_tready;
    assign pop        = fifo_pop & fifo_valid;
    assign fifo_valid = (count != '0);
    assign fifo_beat  = mem[rd_ptr];

    // beat storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= ss_beat;
    end

    //************************************************************
    // pointers and occupancy
    //************************************************************

    always_ff @(posedge clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/fir_mac_engine.sv
/* FIR tap-serial multiply-accumulate engine */

`timescale 1ns/1ps

`include "fir_defs.svh"

module fir_mac_engine
(
    input  logic                     clk,
    input  logic                     axis_rst_n,
    input  logic                     run_start,
    input  fir_pkg::fir_data_t       data_length,
    input  fir_pkg::fir_tap_bank_t   taps,
    input  logic                     fifo_valid,
    input  fir_pkg::fir_axis_beat_t  fifo_beat,
    input  logic                     sm_tready,
    output logic                     fifo_pop,
    output logic                     sm_tvalid,
    output fir_pkg::fir_axis_beat_t  sm_beat,
    output logic                     run_done
);
    import fir_pkg::*;

    localparam int NUM_TAPS = `FIR_NUM_TAPS;
    localparam int PTR_W    = $clog2(NUM_TAPS);

    typedef enum logic [1:0] {
        IDLE_S,
        ACC_S,
        OUT_S
    } state_t;

    state_t              state;
    // first accumulate cycle shifts the popped sample into the history
    logic                shift_pend;
    logic [PTR_W-1:0]    tap_ptr;
    logic                tap_last;
    logic                out_fire;
    fir_data_t           hist [NUM_TAPS];
    fir_data_t           x_q;
    fir_data_t           acc;
    fir_data_t           product;
    fir_data_t           acc_next;
    fir_data_t           out_count;

    //************************************************************
    // handshakes
    //************************************************************

    // no pop while a result is pending, so back-pressure reaches the FIFO
    assign fifo_pop  = (state == IDLE_S) & fifo_valid;
    assign sm_tvalid = (state == OUT_S);
    assign out_fire  = sm_tvalid & sm_tready;
    assign run_done  = out_fire & sm_beat.last;

    // hist[i] is x[n-i], products and sum wrap at 32 bits
    assign product  = taps[tap_ptr] * hist[tap_ptr];
    assign acc_next = acc + product;
    assign tap_last = (tap_ptr == PTR_W'(NUM_TAPS - 1));

    //************************************************************
    // sequencing
    //************************************************************

    always_ff @(posedge clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            state      <= IDLE_S;
            shift_pend <= 1'b0;
            tap_ptr    <= '0;
            out_count  <= '0;
        end
        else if (run_start)
        begin
            state      <= IDLE_S;
            shift_pend <= 1'b0;
            tap_ptr    <= '0;
            out_count  <= '0;
        end
        else
        begin
            case (state)
                IDLE_S:
                begin
                    if (fifo_pop)
                    begin
                        state      <= ACC_S;
                        shift_pend <= 1'b1;
                        tap_ptr    <= '0;
                    end
                end
                ACC_S:
                begin
                    if (shift_pend)
                        shift_pend <= 1'b0;
                    else if (tap_last)
                        state <= OUT_S;
                    else
                        tap_ptr <= tap_ptr + 1'b1;
                end
                OUT_S:
                begin
                    // result held until the sink takes it
                    if (sm_tready)
                    begin
                        state     <= IDLE_S;
                        out_count <= out_count + 1'b1;
                    end
                end
                default: state <= IDLE_S;
            endcase
        end
    end

    //************************************************************
    // datapath
    //************************************************************

    always_ff @(posedge clk)
    begin
        if (fifo_pop)
            x_q <= fifo_beat.data;

        // samples before the run count as zero
        if (run_start)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
                hist[i] <= '0;
        end
        else if ((state == ACC_S) && shift_pend)
        begin
            hist[0] <= x_q;
            for (int i = 1; i < NUM_TAPS; i++)
                hist[i] <= hist[i-1];
        end

        if (state == ACC_S)
            acc <= shift_pend ? '0 : acc_next;

        // final tap lands straight in the output beat
        if ((state == ACC_S) && !shift_pend && tap_last)
        begin
            sm_beat.data <= acc_next;
            sm_beat.last <= ((out_count + 1'b1) == data_length);
        end
    end

endmodule

// File: source/fir_top.sv
/* FIR filter top level */

`timescale 1ns/1ps

module fir_top
(
    input  logic                clk,
    input  logic                axis_rst_n,
    input  logic                awvalid,
    input  fir_pkg::fir_addr_t  awaddr,
    input  logic                wvalid,
    input  fir_pkg::fir_data_t  wdata,
    input  logic                arvalid,
    input  fir_pkg::fir_addr_t  araddr,
    input  logic                rready,
    input  logic                ss_tvalid,
    input  fir_pkg::fir_data_t  ss_tdata,
    input  logic                ss_tlast,
    input  logic                sm_tready,
    output logic                awready,
    output logic                wready,
    output logic                arready,
    output logic                rvalid,
    output fir_pkg::fir_data_t  rdata,
    output logic                ss_tready,
    output logic                sm_tvalid,
    output fir_pkg::fir_data_t  sm_tdata,
    output logic                sm_tlast
);
    import fir_pkg::*;

    // register block to engine
    logic            run_start;
    logic            run_active;
    logic            run_done;
    fir_data_t       data_length;
    fir_tap_bank_t   taps;

    // FIFO to engine
    logic            fifo_valid;
    logic            fifo_pop;
    fir_axis_beat_t  fifo_beat;

    // stream beats at the edge
    fir_axis_beat_t  ss_beat;
    fir_axis_beat_t  sm_beat;

    assign ss_beat  = '{data: ss_tdata, last: ss_tlast};
    assign sm_tdata = sm_beat.data;
    assign sm_tlast = sm_beat.last;

    fir_ctrl_regs u_ctrl_regs (
        .clk(clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .arvalid(arvalid), .araddr(araddr), .rready(rready), .run_done(run_done),
        .awready(awready), .wready(wready), .arready(arready), .rvalid(rvalid),
        .rdata(rdata), .run_start(run_start), .run_active(run_active),
        .data_length(data_length), .taps(taps)
    );

    fir_sample_fifo u_sample_fifo (
        .clk(clk), .axis_rst_n(axis_rst_n), .run_active(run_active),
        .ss_tvalid(ss_tvalid), .ss_beat(ss_beat), .fifo_pop(fifo_pop),
        .ss_tready(ss_tready), .fifo_valid(fifo_valid), .fifo_beat(fifo_beat)
    );

    fir_mac_engine u_mac_engine (
        .clk(clk), .axis_rst_n(axis_rst_n), .run_start(run_start),
        .data_length(data_length), .taps(taps),
        .fifo_valid(fifo_valid), .fifo_beat(fifo_beat), .sm_tready(sm_tready),
        .fifo_pop(fifo_pop), .sm_tvalid(sm_tvalid), .sm_beat(sm_beat),
        .run_done(run_done)
    );

endmodule

// File: bench/fir_clock_gen.sv
/* FIR testbench clock and reset */

`timescale 1ns/1ps

module fir_clock_gen
#(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 5
)
(
    output logic clk,
    output logic axis_rst_n
);

    // 20 ns period, first rising edge at 10 ns
    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset low for a few rising edges, released on a falling edge
    initial
    begin
        axis_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        axis_rst_n = 1'b1;
    end

endmodule

// File: bench/fir_tb.sv
/* FIR filter testbench */

`timescale 1ns/1ps

`include "fir_defs.svh"

module fir_tb;
    import fir_pkg::*;

    localparam int MAX_LEN   = 10;
    localparam int NUM_WORDS = `FIR_NUM_TAPS + 1 + 2 * MAX_LEN;
    // first sample word and first expected output word in the data file
    localparam int X_BASE    = `FIR_NUM_TAPS + 1;
    localparam int Y_BASE    = X_BASE + MAX_LEN;
    // cycles any single wait may take
    localparam int WAIT_MAX  = 300;

    logic            clk;
    logic            axis_rst_n;
    logic            awvalid;
    fir_addr_t       awaddr;
    logic            wvalid;
    fir_data_t       wdata;
    logic            arvalid;
    fir_addr_t       araddr;
    logic            rready;
    logic            ss_tvalid;
    fir_data_t       ss_tdata;
    logic            ss_tlast;
    logic            sm_tready;
    logic            awready;
    logic            wready;
    logic            arready;
    logic            rvalid;
    fir_data_t       rdata;
    logic            ss_tready;
    logic            sm_tvalid;
    fir_data_t       sm_tdata;
    logic            sm_tlast;

    // taps, length, samples, expected outputs
    fir_data_t       vec [NUM_WORDS];
    int              data_len;
    integer          seed;
    // output side ready pattern, 1 for random back-pressure
    logic            random_ready;
    int              check_count;
    int              err_count;
    int              timeout_count;

    fir_clock_gen clk_gen (
        .clk(clk),
        .axis_rst_n(axis_rst_n)
    );

    fir_top dut0 (
        .clk(clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
        .arvalid(arvalid), .araddr(araddr), .rready(rready),
        .ss_tvalid(ss_tvalid), .ss_tdata(ss_tdata), .ss_tlast(ss_tlast),
        .sm_tready(sm_tready),
        .awready(awready), .wready(wready), .arready(arready), .rvalid(rvalid),
        .rdata(rdata), .ss_tready(ss_tready),
        .sm_tvalid(sm_tvalid), .sm_tdata(sm_tdata), .sm_tlast(sm_tlast)
    );

    //************************************************************
    // report and compare
    //************************************************************

    task automatic report_and_finish();
        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, err_count, timeout_count);
        if ((err_count == 0) && (timeout_count == 0))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    endtask

    task automatic note_timeout(input string what);
        $display("Timeout at %0t ns: %s never came", $time, what);
        timeout_count++;
    endtask

    task automatic check_word(input string what, input fir_data_t got, input fir_data_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_beat(input string what, input fir_axis_beat_t got,
                              input fir_axis_beat_t exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error at %0t ns: %s is data %h last %b, expected data %h last %b",
                     $time, what, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic check_status(input string what, input fir_ctrl_word_u got,
                                input fir_ctrl_word_u exp);
        check_count++;
        if (got.raw !== exp.raw)
        begin
            err_count++;
            $display("Error at %0t ns: %s is idle %b done %b start %b (raw %h), expected %h",
                     $time, what, got.f.ap_idle, got.f.ap_done, got.f.ap_start,
                     got.raw, exp.raw);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    //************************************************************
    // register port access
    //************************************************************

    // address and data together, taken on the next rising edge
    task automatic write_reg(input fir_addr_t addr, input fir_data_t data);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        // both readies follow the two valids within the cycle
        #1;
        check_flag("awready on a register write", awready, 1'b1);
        check_flag("wready on a register write", wready, 1'b1);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input fir_addr_t addr, output fir_data_t data);
        int n;
        n = 0;
        @(negedge clk);
        // arready follows arvalid once no read data is pending
        while (rvalid && (n < WAIT_MAX))
        begin
            n++;
            @(negedge clk);
        end
        if (rvalid)
            note_timeout("rvalid low before a register read");
        arvalid = 1'b1;
        araddr  = addr;
        #1;
        check_flag("arready on a register read", arready, 1'b1);
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && (n < WAIT_MAX))
        begin
            n++;
            @(negedge clk);
        end
        if (!rvalid)
            note_timeout("rvalid for a register read");
        data   = rdata;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    //************************************************************
    // stream sides
    //************************************************************

    // back to back samples, last flagged on the final one
    task automatic push_samples();
        int k;
        int n;
        k = 0;
        n = 0;
        while ((k < data_len) && (n <= WAIT_MAX))
        begin
            @(negedge clk);
            ss_tvalid = 1'b1;
            ss_tdata  = vec[X_BASE + k];
            ss_tlast  = (k == data_len - 1);
            // ss_tready comes from registers only, so it holds through the next rising edge
            if (ss_tready)
            begin
                k++;
                n = 0;
            end
            else
            begin
                n++;
            end
        end
        if (k < data_len)
            note_timeout("ss_tready for an input sample");
        @(negedge clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_outputs();
        int             k;
        int             n;
        int             rnd;
        logic           ready;
        fir_axis_beat_t got;
        fir_axis_beat_t exp;
        k = 0;
        n = 0;
        while ((k < data_len) && (n <= WAIT_MAX))
        begin
            @(negedge clk);
            rnd       = $random(seed);
            ready     = random_ready ? rnd[0] : 1'b1;
            sm_tready = ready;
            // beat seen here is taken on the next rising edge
            if (sm_tvalid && ready)
            begin
                got = '{data: sm_tdata, last: sm_tlast};
                exp = '{data: vec[Y_BASE + k], last: (k == data_len - 1)};
                check_beat($sformatf("output beat %0d", k), got, exp);
                k++;
                n = 0;
            end
            else
            begin
                n++;
            end
        end
        if (k < data_len)
            note_timeout($sformatf("output beat %0d", k));
        @(negedge clk);
        sm_tready = 1'b0;
        check_flag("sm_tvalid after the last beat", sm_tvalid, 1'b0);
    endtask

    // one full run, status checked at the end
    task automatic run_filter(input logic rand_mode);
        fir_data_t      word;
        fir_ctrl_word_u st;
        fir_ctrl_word_u exp_st;
        random_ready = rand_mode;
        write_reg(`FIR_ADDR_CTRL, 32'h1);
        fork
            push_samples();
            collect_outputs();
        join
        read_reg(`FIR_ADDR_CTRL, word);
        st.raw           = word;
        exp_st.raw       = '0;
        exp_st.f.ap_idle = 1'b1;
        exp_st.f.ap_done = 1'b1;
        check_status("status after the run", st, exp_st);
        // done clears on the first read
        read_reg(`FIR_ADDR_CTRL, word);
        st.raw           = word;
        exp_st.f.ap_done = 1'b0;
        check_status("status on a second read", st, exp_st);
    endtask

    //************************************************************
    // main sequence
    //************************************************************

    initial
    begin
        fir_data_t      word;
        fir_ctrl_word_u st;
        fir_ctrl_word_u exp_st;
        int             n;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        arvalid       = 1'b0;
        araddr        = '0;
        rready        = 1'b0;
        ss_tvalid     = 1'b0;
        ss_tdata      = '0;
        ss_tlast      = 1'b0;
        sm_tready     = 1'b0;
        random_ready  = 1'b0;
        seed          = 32'h8a8d;
        check_count   = 0;
        err_count     = 0;
        timeout_count = 0;

        $readmemh("bench/fir_testdata.txt", vec);
        data_len = int'(vec[`FIR_NUM_TAPS]);
        if ((data_len < 1) || (data_len > MAX_LEN))
        begin
            $display("Data file gives a length of %0d, outside 1 to %0d", data_len, MAX_LEN);
            err_count++;
        end
        else
        begin
            n = 0;
            while ((axis_rst_n !== 1'b1) && (n < WAIT_MAX))
            begin
                n++;
                @(negedge clk);
            end
            if (axis_rst_n !== 1'b1)
                note_timeout("reset release");

            // no stream or read activity out of reset
            check_flag("ss_tready after reset", ss_tready, 1'b0);
            check_flag("sm_tvalid after reset", sm_tvalid, 1'b0);
            check_flag("rvalid after reset", rvalid, 1'b0);

            // idle after reset, unmapped address reads all ones
            read_reg(`FIR_ADDR_CTRL, word);
            st.raw           = word;
            exp_st.raw       = '0;
            exp_st.f.ap_idle = 1'b1;
            check_status("status after reset", st, exp_st);
            read_reg(12'h300, word);
            check_word("unmapped address 0x300", word, '1);

            // configuration and read-back
            for (int i = 0; i < `FIR_NUM_TAPS; i++)
                write_reg(fir_addr_t'(`FIR_ADDR_TAP0 + 4 * i), vec[i]);
            write_reg(`FIR_ADDR_LEN, vec[`FIR_NUM_TAPS]);
            for (int i = 0; i < `FIR_NUM_TAPS; i++)
            begin
                read_reg(fir_addr_t'(`FIR_ADDR_TAP0 + 4 * i), word);
                check_word($sformatf("tap %0d read-back", i), word, vec[i]);
            end
            read_reg(`FIR_ADDR_LEN, word);
            check_word("data length read-back", word, vec[`FIR_NUM_TAPS]);

            // sink always ready, then random back-pressure
            run_filter(1'b0);
            run_filter(1'b1);
        end

        report_and_finish();
    end

endmodule

// File: all.f
+incdir+include
source/fir_pkg.sv
source/fir_ctrl_regs.sv
source/fir_sample_fifo.sv
source/fir_mac_engine.sv
source/fir_top.sv
bench/fir_clock_gen.sv
bench/fir_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the FIR testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module fir_tb -f all.f -o fir_sim \
    > build.log 2>&1 \
    && ./obj_dir/fir_sim > sim.log 2>&1 \
    || { echo "build or simulation step failed, see build.log and sim.log"; exit 1; }
grep -q "Test failures found" sim.log \
    && { echo "FAIL: see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }

// File: bench/fir_testdata.txt
// FIR test vectors, one 32-bit hex word per line
// taps 0..10, then data length, then input samples, then expected outputs
00000001 // tap 0
00000002
00000003
00000004
00000005
00000006
00000007
00000008
00000009
0000000a
0000000b // tap 10
0000000a // data length
80000000 // sample 0, products with it wrap
00000002
00000003
00000004
00000005
00000006
00000007
00000008
00000009
ffffffff // sample 9
80000000 // output 0
00000002
80000007
00000010
8000001e
00000032
8000004d
00000070
8000009c
000000c7 // output 9
